/* include/page_walker_macros.svh */
// ********************
// widths, PTE flag positions, CSR numbers and the bus tag of the page walker
// included by the RTL and the testbench
// ********************
`ifndef PAGE_WALKER_MACROS_SVH
`define PAGE_WALKER_MACROS_SVH

// address and frame widths
`define PW_VA_W        44
`define PW_PPN_W       30
`define PW_PAGE_SHIFT  14
`define PW_IDX_W       10
`define PW_PTE_W       64
`define PW_LEVEL_W     2

// control registers
`define PW_CSR_NO_W    16
`define PW_CSR_ROOT0   16'h0180
`define PW_CSR_ROOT1   16'h0181

// memory response tag owned by this walker
`define PW_TAG_W       9
`define PW_WALK_TAG    9'h1fc

// pte flag bits
`define PW_PTE_VALID   0
`define PW_PTE_LEAF    1
`define PW_PTE_WR      2
`define PW_PTE_USER    3
`define PW_PTE_NX      4

`endif

/* hw/page_walker_pkg.sv */
// ********************
// page table entry types, one word seen as table pointer or as leaf
// ********************
`include "page_walker_macros.svh"

package page_walker_pkg;

  // pointer to the next table level
  typedef struct packed {
    logic [`PW_PTE_W-`PW_VA_W-1:0]   rsvd_hi;
    logic [`PW_PPN_W-1:0]            frame;
    logic [`PW_PAGE_SHIFT-2:0]       rsvd_lo;
    logic                            valid;
  } pte_table_t;

  // final translation, also used for huge pages at levels 2 and 1
  typedef struct packed {
    logic [`PW_PTE_W-`PW_VA_W-1:0]   rsvd_hi;
    logic [`PW_PPN_W-1:0]            frame;
    logic [`PW_PAGE_SHIFT-6:0]       rsvd_lo;
    logic                            nx;
    logic                            user;
    logic                            wr;
    logic                            leaf;
    logic                            valid;
  } pte_leaf_t;

  typedef union packed {
    pte_table_t as_table;
    pte_leaf_t  as_leaf;
  } pte_u;

endpackage

/* hw/walk_csr.sv */
// ********************
// root pointer registers and paging flag
// written through the control register strobe
// ********************
`timescale 1ns/1ns
`include "page_walker_macros.svh"

module walk_csr (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    csr_en,
  input  logic [`PW_CSR_NO_W-1:0] csr_no,
  input  logic [`PW_PTE_W-1:0]    csr_data,
  output logic [`PW_PPN_W-1:0]    root0,
  output logic [`PW_PPN_W-1:0]    root1,
  output logic                    paging_en
);

  logic hit_root0;
  logic hit_root1;

  assign hit_root0 = csr_en & (csr_no == `PW_CSR_ROOT0);
  assign hit_root1 = csr_en & (csr_no == `PW_CSR_ROOT1);

  always_ff @(posedge clk) begin
    if (rst) begin
      root0     <= '0;
      root1     <= '0;
      paging_en <= 1'b0;
    end else begin
      // only the frame number of the root is kept
      if (hit_root0) begin
        root0 <= csr_data[`PW_PPN_W-1:0];
      end
      if (hit_root1) begin
        root1 <= csr_data[`PW_PPN_W-1:0];
      end
      // sticky until reset
      if (hit_root0 | hit_root1) begin
        paging_en <= 1'b1;
      end
    end
  end

endmodule

/* hw/pte_decode.sv */
// ********************
// decodes one returned PTE at the current level
// gives leaf or fault, the next entry address and the TLB fields
// ********************
`timescale 1ns/1ns
`include "page_walker_macros.svh"

module pte_decode (
  input  page_walker_pkg::pte_u    pte,
  input  logic [`PW_LEVEL_W-1:0]   level,
  input  logic [`PW_VA_W-1:0]      va,
  output logic                     leaf,
  output logic                     fault,
  output logic [`PW_VA_W-1:0]      next_addr,
  output logic [`PW_PPN_W-1:0]     ppn,
  output logic                     wr,
  output logic                     user,
  output logic                     nx
);

  logic                  valid;
  logic [`PW_IDX_W-1:0]  idx_next;
  logic [`PW_PPN_W-1:0]  leaf_ppn;

  assign valid = pte.as_leaf.valid;
  assign fault = ~valid;
  // level 0 entries are always final
  assign leaf  = valid & (pte.as_leaf.leaf | (level == 2'd0));

  // index into the table one level down
  always_comb begin
    case (level)
      2'd2:    idx_next = va[`PW_PAGE_SHIFT+`PW_IDX_W +: `PW_IDX_W];
      2'd1:    idx_next = va[`PW_PAGE_SHIFT +: `PW_IDX_W];
      default: idx_next = '0;
    endcase
  end

  // 8 byte entries, top address bit stays zero
  assign next_addr = {1'b0, pte.as_table.frame, idx_next, 3'b000};

  // huge pages take their low frame bits from the virtual address
  always_comb begin
    case (level)
      2'd2: begin
        leaf_ppn = {pte.as_leaf.frame[`PW_PPN_W-1:2*`PW_IDX_W],
                    va[`PW_PAGE_SHIFT+2*`PW_IDX_W-1:`PW_PAGE_SHIFT]};
      end
      2'd1: begin
        leaf_ppn = {pte.as_leaf.frame[`PW_PPN_W-1:`PW_IDX_W],
                    va[`PW_PAGE_SHIFT+`PW_IDX_W-1:`PW_PAGE_SHIFT]};
      end
      default: begin
        leaf_ppn = pte.as_leaf.frame;
      end
    endcase
  end

  // fault entries carry no frame and no rights
  assign ppn  = valid ? leaf_ppn : '0;
  assign wr   = valid & pte.as_leaf.wr;
  assign user = valid & pte.as_leaf.user;
  assign nx   = valid & pte.as_leaf.nx;

  // the walk starts at 2 and stops at 0
  always_comb begin
    assert (level != 2'd3)
      else $error("pte_decode: walk level out of range");
  end

endmodule

/* hw/walk_ctrl.sv */
// ********************
// walk FSM for one channel, issues one table read per level
// and writes the finished translation to the TLB
// ********************
`timescale 1ns/1ns
`include "page_walker_macros.svh"

module walk_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   new_en,
  input  logic [`PW_VA_W-1:0]    new_addr,
  input  logic [`PW_PPN_W-1:0]   root0,
  input  logic [`PW_PPN_W-1:0]   root1,
  input  logic                   paging_en,
  input  logic                   mem_hold,
  input  logic                   mem_rsp_valid,
  input  logic [`PW_TAG_W-1:0]   mem_rsp_tag,
  input  logic [`PW_PTE_W-1:0]   mem_rsp_data,
  input  logic                   leaf,
  input  logic                   fault,
  input  logic [`PW_VA_W-1:0]    next_addr,
  input  logic [`PW_PPN_W-1:0]   ppn,
  input  logic                   wr,
  input  logic                   user,
  input  logic                   nx,
  output logic                   new_can,
  output logic                   mem_req,
  output logic [`PW_VA_W-1:0]    mem_addr,
  output page_walker_pkg::pte_u  pte,
  output logic [`PW_LEVEL_W-1:0] level,
  output logic [`PW_VA_W-1:0]    va,
  output logic                   tlb_wen,
  output logic [`PW_PPN_W-1:0]   tlb_vpn,
  output logic [`PW_PPN_W-1:0]   tlb_ppn,
  output logic                   tlb_wr,
  output logic                   tlb_user,
  output logic                   tlb_nx,
  output logic                   tlb_fault
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_REQ   = 2'd1;
  localparam logic [1:0] S_WAIT  = 2'd2;
  localparam logic [1:0] S_WRITE = 2'd3;

  logic [1:0]             state;
  logic [`PW_LEVEL_W-1:0] level_q;
  logic [`PW_VA_W-1:0]    va_q;
  logic [`PW_VA_W-1:0]    addr_q;
  logic [`PW_PPN_W-1:0]   ppn_q;
  logic                   wr_q;
  logic                   user_q;
  logic                   nx_q;
  logic                   fault_q;
  logic                   accept;
  logic                   rsp_hit;
  logic                   done;
  logic [`PW_PPN_W-1:0]   root_sel;

  assign accept   = new_en & new_can;
  // only our own tag, and only while a read is out
  assign rsp_hit  = (state == S_WAIT) & mem_rsp_valid & (mem_rsp_tag == `PW_WALK_TAG);
  assign done     = leaf | fault;
  assign root_sel = new_addr[`PW_VA_W-1] ? root1 : root0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      level_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            state   <= paging_en ? S_REQ : S_WRITE;
            level_q <= 2'd2;
          end
        end
        S_REQ: begin
          if (!mem_hold) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp_hit) begin
            if (done) begin
              state <= S_WRITE;
            end else begin
              state   <= S_REQ;
              level_q <= level_q - 2'd1;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // address and translation payload
  always_ff @(posedge clk) begin
    if (accept) begin
      va_q    <= new_addr;
      // top level entry, zero top bit keeps the byte address at 44 bits
      addr_q  <= {1'b0, root_sel,
                  new_addr[`PW_PAGE_SHIFT+2*`PW_IDX_W +: `PW_IDX_W], 3'b000};
      // identity entry for paging off, replaced by the walk otherwise
      ppn_q   <= new_addr[`PW_VA_W-1:`PW_PAGE_SHIFT];
      wr_q    <= 1'b1;
      user_q  <= 1'b1;
      nx_q    <= 1'b0;
      fault_q <= 1'b0;
    end else if (rsp_hit) begin
      addr_q  <= next_addr;
      ppn_q   <= ppn;
      wr_q    <= wr;
      user_q  <= user;
      nx_q    <= nx;
      fault_q <= fault;
    end
  end

  // the returned word is decoded in the cycle it arrives
  assign pte   = mem_rsp_data;
  assign level = level_q;
  assign va    = va_q;

  assign new_can  = (state == S_IDLE);
  assign mem_req  = (state == S_REQ) & ~mem_hold;
  assign mem_addr = addr_q;

  assign tlb_wen   = (state == S_WRITE);
  assign tlb_vpn   = va_q[`PW_VA_W-1:`PW_PAGE_SHIFT];
  assign tlb_ppn   = ppn_q;
  assign tlb_wr    = wr_q;
  assign tlb_user  = user_q;
  assign tlb_nx    = nx_q;
  assign tlb_fault = fault_q;

  // a held request waits with its address unchanged
  a_hold_waits: assert property (@(posedge clk) disable iff (rst)
    (state == S_REQ) && mem_hold |=> (state == S_REQ) && $stable(mem_addr));

  a_wen_single: assert property (@(posedge clk) disable iff (rst)
    tlb_wen |=> !tlb_wen);

endmodule

/* hw/page_walker.sv */
// ********************
// page walker top, one channel
// control registers, walk FSM and PTE decoder
// ********************
`timescale 1ns/1ns
`include "page_walker_macros.svh"

module page_walker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    new_en,
  input  logic [`PW_VA_W-1:0]     new_addr,
  output logic                    new_can,
  input  logic                    csr_en,
  input  logic [`PW_CSR_NO_W-1:0] csr_no,
  input  logic [`PW_PTE_W-1:0]    csr_data,
  output logic                    mem_req,
  output logic [`PW_VA_W-1:0]     mem_addr,
  input  logic                    mem_hold,
  input  logic                    mem_rsp_valid,
  input  logic [`PW_TAG_W-1:0]    mem_rsp_tag,
  input  logic [`PW_PTE_W-1:0]    mem_rsp_data,
  output logic                    tlb_wen,
  output logic [`PW_PPN_W-1:0]    tlb_vpn,
  output logic [`PW_PPN_W-1:0]    tlb_ppn,
  output logic                    tlb_wr,
  output logic                    tlb_user,
  output logic                    tlb_nx,
  output logic                    tlb_fault
);

  logic [`PW_PPN_W-1:0]   root0;
  logic [`PW_PPN_W-1:0]   root1;
  logic                   paging_en;
  page_walker_pkg::pte_u  pte;
  logic [`PW_LEVEL_W-1:0] level;
  logic [`PW_VA_W-1:0]    va;
  logic                   dec_leaf;
  logic                   dec_fault;
  logic [`PW_VA_W-1:0]    dec_next_addr;
  logic [`PW_PPN_W-1:0]   dec_ppn;
  logic                   dec_wr;
  logic                   dec_user;
  logic                   dec_nx;

  walk_csr u_csr (
    .clk       (clk),
    .rst       (rst),
    .csr_en    (csr_en),
    .csr_no    (csr_no),
    .csr_data  (csr_data),
    .root0     (root0),
    .root1     (root1),
    .paging_en (paging_en)
  );

  walk_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .new_en        (new_en),
    .new_addr      (new_addr),
    .root0         (root0),
    .root1         (root1),
    .paging_en     (paging_en),
    .mem_hold      (mem_hold),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_tag   (mem_rsp_tag),
    .mem_rsp_data  (mem_rsp_data),
    .leaf          (dec_leaf),
    .fault         (dec_fault),
    .next_addr     (dec_next_addr),
    .ppn           (dec_ppn),
    .wr            (dec_wr),
    .user          (dec_user),
    .nx            (dec_nx),
    .new_can       (new_can),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .pte           (pte),
    .level         (level),
    .va            (va),
    .tlb_wen       (tlb_wen),
    .tlb_vpn       (tlb_vpn),
    .tlb_ppn       (tlb_ppn),
    .tlb_wr        (tlb_wr),
    .tlb_user      (tlb_user),
    .tlb_nx        (tlb_nx),
    .tlb_fault     (tlb_fault)
  );

  pte_decode u_dec (
    .pte       (pte),
    .level     (level),
    .va        (va),
    .leaf      (dec_leaf),
    .fault     (dec_fault),
    .next_addr (dec_next_addr),
    .ppn       (dec_ppn),
    .wr        (dec_wr),
    .user      (dec_user),
    .nx        (dec_nx)
  );

endmodule

/* sim/page_walker_tb.sv */
// ********************
// directed tests for the page walker with a sparse table memory
// ********************
`timescale 1ns/1ns
`include "page_walker_macros.svh"

module page_walker_tb;

  localparam int TEST_COUNT      = 6;
  localparam int WALK_MAX_CYCLES = 40;
  // up to four walks per test, doubled for margin
  localparam int WATCHDOG_CYCLES = TEST_COUNT * 4 * WALK_MAX_CYCLES * 2;
  localparam logic [`PW_PPN_W-1:0] ROOT0_FRAME = 30'h0001_2340;
  localparam logic [`PW_PPN_W-1:0] ROOT1_FRAME = 30'h0abc_de00;
  localparam logic [`PW_TAG_W-1:0] FOREIGN_TAG = 9'h0a3;

  logic                    clk;
  logic                    rst;
  logic                    new_en;
  logic [`PW_VA_W-1:0]     new_addr;
  logic                    new_can;
  logic                    csr_en;
  logic [`PW_CSR_NO_W-1:0] csr_no;
  logic [`PW_PTE_W-1:0]    csr_data;
  logic                    mem_req;
  logic [`PW_VA_W-1:0]     mem_addr;
  logic                    mem_hold;
  logic                    mem_rsp_valid;
  logic [`PW_TAG_W-1:0]    mem_rsp_tag;
  logic [`PW_PTE_W-1:0]    mem_rsp_data;
  logic                    tlb_wen;
  logic [`PW_PPN_W-1:0]    tlb_vpn;
  logic [`PW_PPN_W-1:0]    tlb_ppn;
  logic                    tlb_wr;
  logic                    tlb_user;
  logic                    tlb_nx;
  logic                    tlb_fault;

  logic [`PW_PTE_W-1:0]    mem [logic [`PW_VA_W-1:0]];
  logic [`PW_VA_W-1:0]     seen_addr[$];
  logic [15:0]             lfsr;
  logic                    foreign_rsp;
  int                      checks;
  int                      errors;

  page_walker UUT (
    .clk           (clk),
    .rst           (rst),
    .new_en        (new_en),
    .new_addr      (new_addr),
    .new_can       (new_can),
    .csr_en        (csr_en),
    .csr_no        (csr_no),
    .csr_data      (csr_data),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .mem_hold      (mem_hold),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_tag   (mem_rsp_tag),
    .mem_rsp_data  (mem_rsp_data),
    .tlb_wen       (tlb_wen),
    .tlb_vpn       (tlb_vpn),
    .tlb_ppn       (tlb_ppn),
    .tlb_wr        (tlb_wr),
    .tlb_user      (tlb_user),
    .tlb_nx        (tlb_nx),
    .tlb_fault     (tlb_fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic page_walker_pkg::pte_u make_pte(input logic [`PW_PPN_W-1:0] frame,
      input logic valid, input logic leaf, input logic wr, input logic user, input logic nx);
    page_walker_pkg::pte_u p;
    p = '0;
    p.as_leaf.frame = frame;
    p.as_leaf.valid = valid;
    p.as_leaf.leaf  = leaf;
    p.as_leaf.wr    = wr;
    p.as_leaf.user  = user;
    p.as_leaf.nx    = nx;
    return p;
  endfunction

  function automatic page_walker_pkg::pte_u make_table(input logic [`PW_PPN_W-1:0] frame);
    page_walker_pkg::pte_u p;
    p = '0;
    p.as_table.frame = frame;
    p.as_table.valid = 1'b1;
    return p;
  endfunction

  function automatic logic [`PW_VA_W-1:0] entry_addr(input logic [`PW_PPN_W-1:0] frame,
      input logic [`PW_VA_W-1:0] va, input int level);
    logic [`PW_IDX_W-1:0] idx;
    idx = va[`PW_PAGE_SHIFT + `PW_IDX_W*level +: `PW_IDX_W];
    return {1'b0, frame, idx, 3'b000};
  endfunction

  // huge page, low frame bits come from the virtual address
  function automatic logic [`PW_PPN_W-1:0] leaf_frame(input logic [`PW_PPN_W-1:0] frame,
      input logic [`PW_VA_W-1:0] va, input int level);
    logic [`PW_PPN_W-1:0] mask;
    mask = (30'd1 << (`PW_IDX_W*level)) - 30'd1;
    return (frame & ~mask) | (va[`PW_VA_W-1:`PW_PAGE_SHIFT] & mask);
  endfunction

  // table memory, answers each read after 1 to 4 cycles
  initial begin : mem_model
    logic [`PW_VA_W-1:0]  addr;
    logic [`PW_PTE_W-1:0] data;
    logic [1:0]           draw;
    lfsr          = 16'd19830;
    mem_rsp_valid = 1'b0;
    mem_rsp_tag   = '0;
    mem_rsp_data  = '0;
    forever begin
      @(negedge clk);
      if (mem_req) begin
        addr = mem_addr;
        seen_addr.push_back(addr);
        data = mem.exists(addr) ? mem[addr] : '0;
        lfsr    = lfsr_step(lfsr);
        draw[0] = lfsr[0];
        lfsr    = lfsr_step(lfsr);
        draw[1] = lfsr[0];
        repeat (int'(draw) + 1) @(posedge clk);
        #1;
        if (foreign_rsp) begin
          // another unit's response, a valid leaf the walker must not take
          mem_rsp_valid = 1'b1;
          mem_rsp_tag   = FOREIGN_TAG;
          mem_rsp_data  = make_pte(30'h3fff_ffff, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
          @(posedge clk);
          #1;
        end
        mem_rsp_valid = 1'b1;
        mem_rsp_tag   = `PW_WALK_TAG;
        mem_rsp_data  = data;
        @(posedge clk);
        #1;
        mem_rsp_valid = 1'b0;
        mem_rsp_tag   = '0;
        mem_rsp_data  = '0;
      end
    end
  end

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic write_csr(input logic [`PW_CSR_NO_W-1:0] no, input logic [`PW_PTE_W-1:0] data);
    @(posedge clk);
    #1;
    csr_en   = 1'b1;
    csr_no   = no;
    csr_data = data;
    @(posedge clk);
    #1;
    csr_en = 1'b0;
  endtask

  task automatic start_request(input logic [`PW_VA_W-1:0] va, input logic hold);
    @(posedge clk);
    #1;
    new_en   = 1'b1;
    new_addr = va;
    mem_hold = hold;
    @(posedge clk);
    #1;
    new_en = 1'b0;
  endtask

  // called in the tlb_wen cycle, then checks the cycle after
  task automatic check_tlb(input logic [`PW_VA_W-1:0] va, input logic [`PW_PPN_W-1:0] ppn,
      input logic wr, input logic user, input logic nx, input logic fault);
    expect_eq("tlb_wen", 64'(tlb_wen), 64'd1);
    expect_eq("tlb_vpn", 64'(tlb_vpn), 64'(va[`PW_VA_W-1:`PW_PAGE_SHIFT]));
    expect_eq("tlb_ppn", 64'(tlb_ppn), 64'(ppn));
    expect_eq("tlb_wr", 64'(tlb_wr), 64'(wr));
    expect_eq("tlb_user", 64'(tlb_user), 64'(user));
    expect_eq("tlb_nx", 64'(tlb_nx), 64'(nx));
    expect_eq("tlb_fault", 64'(tlb_fault), 64'(fault));
    @(negedge clk);
    expect_eq("tlb_wen", 64'(tlb_wen), 64'd0);
    expect_eq("new_can", 64'(new_can), 64'd1);
  endtask

  // builds the tables down to the stop level and runs one walk
  task automatic run_walk(input logic [`PW_VA_W-1:0] va, input int stop,
      input page_walker_pkg::pte_u last, input int hold_cycles);
    logic [`PW_PPN_W-1:0] frame;
    logic [`PW_VA_W-1:0]  exp_list[$];
    int                   base;
    int                   lvl;
    int                   n;
    frame = va[`PW_VA_W-1] ? ROOT1_FRAME : ROOT0_FRAME;
    for (lvl = 2; lvl >= stop; lvl--) begin
      exp_list.push_back(entry_addr(frame, va, lvl));
      if (lvl == stop) begin
        mem[exp_list[$]] = last;
      end else begin
        frame = 30'h0033_3000 + 30'(lvl);
        mem[exp_list[$]] = make_table(frame);
      end
    end
    base = seen_addr.size();
    start_request(va, hold_cycles > 0);
    repeat (hold_cycles) begin
      @(negedge clk);
      expect_eq("mem_req", 64'(mem_req), 64'd0);
    end
    if (hold_cycles > 0) begin
      @(posedge clk);
      #1;
      mem_hold = 1'b0;
    end
    n = 0;
    while (!tlb_wen && n < WALK_MAX_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!tlb_wen) begin
      errors++;
      $display("walk for va %h gave no TLB write", va);
      return;
    end
    if (seen_addr.size() - base != exp_list.size()) begin
      errors++;
      $display("walk made %0d table reads, expected %0d", seen_addr.size() - base,
               exp_list.size());
    end else begin
      for (lvl = 0; lvl < exp_list.size(); lvl++) begin
        expect_eq("mem_addr", 64'(seen_addr[base + lvl]), 64'(exp_list[lvl]));
      end
    end
    if (last.as_leaf.valid) begin
      check_tlb(va, leaf_frame(last.as_leaf.frame, va, stop), last.as_leaf.wr,
                last.as_leaf.user, last.as_leaf.nx, 1'b0);
    end else begin
      check_tlb(va, '0, 1'b0, 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic reset_state();
    @(negedge clk);
    expect_eq("new_can", 64'(new_can), 64'd1);
    expect_eq("mem_req", 64'(mem_req), 64'd0);
    expect_eq("tlb_wen", 64'(tlb_wen), 64'd0);
  endtask

  task automatic paging_off_identity();
    logic [`PW_VA_W-1:0] va;
    int                  base;
    va   = 44'h9ab_cdef_1234;
    base = seen_addr.size();
    start_request(va, 1'b0);
    @(negedge clk);
    check_tlb(va, va[`PW_VA_W-1:`PW_PAGE_SHIFT], 1'b1, 1'b1, 1'b0, 1'b0);
    if (seen_addr.size() != base) begin
      errors++;
      $display("table read issued while paging is off");
    end
  endtask

  task automatic three_level_walks();
    // upper data bits are not part of the root
    write_csr(`PW_CSR_ROOT0, {34'h3_5a5a_5a5a, ROOT0_FRAME});
    write_csr(`PW_CSR_ROOT1, {34'h2_a5a5_a5a5, ROOT1_FRAME});
    run_walk(44'h0a1_2345_6789, 0, make_pte(30'h1555_0aa5, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1), 0);
    run_walk(44'h8f0_0ff0_1357, 0, make_pte(30'h2aaa_5a5a, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0), 0);
  endtask

  task automatic huge_leaf_walks();
    run_walk(44'h123_4567_89ab, 2, make_pte(30'h3c0a_bcde, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0), 0);
    run_walk(44'hfed_cba9_8765, 1, make_pte(30'h1234_5678, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1), 0);
  endtask

  task automatic invalid_entry_walks();
    int lvl;
    for (lvl = 2; lvl >= 0; lvl--) begin
      run_walk(44'h3c3_0f0f_5555, lvl, make_pte(30'h2f0f_0f0f, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1), 0);
    end
  endtask

  task automatic hold_and_foreign_tag();
    foreign_rsp = 1'b1;
    run_walk(44'h456_789a_bcde, 0, make_pte(30'h0765_4321, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0), 5);
    foreign_rsp = 1'b0;
  endtask

  initial begin
    rst         = 1'b1;
    new_en      = 1'b0;
    new_addr    = '0;
    csr_en      = 1'b0;
    csr_no      = '0;
    csr_data    = '0;
    mem_hold    = 1'b0;
    foreign_rsp = 1'b0;
    checks      = 0;
    errors      = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_state();
    paging_off_identity();
    three_level_walks();
    huge_leaf_walks();
    invalid_entry_walks();
    hold_and_foreign_tag();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* page_walker.f */
+incdir+include
hw/page_walker_pkg.sv
hw/walk_csr.sv
hw/pte_decode.sv
hw/walk_ctrl.sv
hw/page_walker.sv
sim/page_walker_tb.sv

/* Makefile */
# Verilator build and run of the page walker testbench
VERILATOR ?= verilator
TOP       ?= page_walker_tb
FILELIST  ?= page_walker.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the result is taken from the log, not from the exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
